// ==== tama_core.f ====
+incdir+test
source/tama_pkg.sv
source/tama_decoder.sv
source/tama_sequencer.sv
source/tama_regfile.sv
source/tama_ram.sv
source/tama_core.sv
test/tama_core_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module tama_core_tb -f tama_core.f --Mdir obj_dir -o tama_core_sim
	./obj_dir/tama_core_sim > sim.log 2>&1; cat sim.log
	@if grep -q "Errors found" sim.log; then \
		echo "Simulation FAILED"; \
		exit 1; \
	elif ! grep -q "No errors" sim.log; then \
		echo "Simulation FAILED, run did not complete"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== test/tama_model.svh ====
`ifndef TAMA_MODEL_SVH
`define TAMA_MODEL_SVH

// Anything outside the supported ranges runs as NOP5
function automatic logic instr_is_illegal(input logic [11:0] word);
    logic known;
    known = ((word >= 12'hE00) && (word <= 12'hE3F)) ||
            ((word >= 12'hB00) && (word <= 12'hBFF)) ||
            ((word >= 12'h800) && (word <= 12'h8FF)) ||
            ((word >= 12'hFC0) && (word <= 12'hFCA)) ||
            ((word >= 12'hFD0) && (word <= 12'hFDA)) ||
            (word == 12'hFFB);
    return !known;
endfunction

// One instruction on the architectural model
function automatic arch_state_t tama_step(input arch_state_t cur,
                                          inout logic [3:0] mem [RAM_DEPTH],
                                          input logic [11:0] word);
    arch_state_t nxt;
    logic [3:0]  val;
    nxt    = cur;
    nxt.pc = cur.pc + 12'd1;
    val    = 4'h0;
    if ((word >= 12'hE00) && (word <= 12'hE3F)) begin
        case (word[5:4])
            2'd0:    nxt.a = word[3:0];
            2'd1:    nxt.b = word[3:0];
            2'd2:    mem[cur.x[7:0]] = word[3:0];
            default: mem[cur.y[7:0]] = word[3:0];
        endcase
    end else if (word[11:8] == 4'hB) begin
        nxt.x[7:0] = word[7:0]; // Page kept
    end else if (word[11:8] == 4'h8) begin
        nxt.y[7:0] = word[7:0];
    end else if ((word >= 12'hFC0) && (word <= 12'hFCA)) begin
        case (word[3:0])
            4'h0:    val = cur.a;
            4'h1:    val = cur.b;
            4'h2:    val = mem[cur.x[7:0]];
            4'h3:    val = mem[cur.y[7:0]];
            4'h4:    val = cur.x[11:8];
            4'h5:    val = cur.x[7:4];
            4'h6:    val = cur.x[3:0];
            4'h7:    val = cur.y[11:8];
            4'h8:    val = cur.y[7:4];
            4'h9:    val = cur.y[3:0];
            default: val = cur.f;
        endcase
        nxt.sp      = cur.sp - 8'd1; // Decrement first
        mem[nxt.sp] = val;
    end else if ((word >= 12'hFD0) && (word <= 12'hFDA)) begin
        val    = mem[cur.sp];
        nxt.sp = cur.sp + 8'd1;
        case (word[3:0])
            4'h0:    nxt.a = val;
            4'h1:    nxt.b = val;
            4'h2:    mem[cur.x[7:0]] = val;
            4'h3:    mem[cur.y[7:0]] = val;
            4'h4:    nxt.x[11:8] = val;
            4'h5:    nxt.x[7:4] = val;
            4'h6:    nxt.x[3:0] = val;
            4'h7:    nxt.y[11:8] = val;
            4'h8:    nxt.y[7:4] = val;
            4'h9:    nxt.y[3:0] = val;
            default: nxt.f = flags_t'(val);
        endcase
    end
    return nxt;
endfunction

`endif

// ==== test/tama_core_tb.sv ====
module tama_core_tb
    import tama_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAM_ADDR_W   = 8;
    localparam int RAM_DEPTH    = 1 << RAM_ADDR_W;
    localparam int N_RANDOM     = 300;
    localparam int RETIRE_LIMIT = 20;
    localparam int RESET_LIMIT  = 40;
    localparam int MARK_LD      = 4;
    localparam int MARK_MEM     = 19;
    localparam int MARK_NIB     = 38;
    localparam int MARK_FLAG    = 44;

    localparam logic [11:0] DIRECTED [MARK_FLAG] = '{
        // A and B through the stack
        12'hE0A, 12'hE15, 12'hFC0, 12'hFD1,
        // M(X) and M(Y) as targets, then an unrelated address
        12'hB34, 12'h856, 12'hE07, 12'hFC0, 12'hFD2, 12'hE0C, 12'hFC0, 12'hFD3,
        12'hFC3, 12'hFD1, 12'hFC2, 12'hFD0, 12'hB77, 12'hFC2, 12'hFD6,
        // Single nibbles of X and Y
        12'hE01, 12'hFC0, 12'hFD4, 12'hE02, 12'hFC0, 12'hFD5,
        12'hE03, 12'hFC0, 12'hFD6, 12'hE0D, 12'hFC0, 12'hFD7,
        12'hE0E, 12'hFC0, 12'hFD8, 12'hE0F, 12'hFC0, 12'hFD9, 12'hB45,
        // Flags
        12'hE0A, 12'hFC0, 12'hFDA, 12'hE03, 12'hFCA, 12'hFD0
    };

    logic        clk;
    logic        arst_n;
    logic [11:0] instr;
    logic [11:0] pc;
    arch_state_t state;
    logic        retire;
    logic        illegal;

    logic [11:0] prog [$];
    arch_state_t model;
    logic [3:0]  model_mem [RAM_DEPTH];
    int          retire_count;
    int          error_count;

    `include "tama_model.svh"

    tama_core #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .instr   (instr),
        .pc      (pc),
        .state   (state),
        .retire  (retire),
        .illegal (illegal)
    );

    always #20 clk = ~clk;

    // Program word at a fetch address, NOP5 off the end
    function automatic logic [11:0] fetch_word(input logic [11:0] addr);
        int idx;
        idx = int'(addr) - int'(RESET_PC);
        if ((idx < 0) || (idx >= prog.size())) begin
            return NOP5;
        end
        return prog[idx];
    endfunction

    function automatic logic [11:0] random_word();
        logic [11:0] word;
        int          tries;
        word  = NOP5;
        tries = 0;
        case ($urandom_range(0, 6))
            0: word = 12'hE00 | 12'($urandom_range(0, 63));
            1: word = 12'hB00 | 12'($urandom_range(0, 255));
            2: word = 12'h800 | 12'($urandom_range(0, 255));
            3: word = 12'hFC0 | 12'($urandom_range(0, 10));
            4: word = 12'hFD0 | 12'($urandom_range(0, 10));
            5: word = NOP5;
            default: begin
                while (!instr_is_illegal(word) && (tries < 32)) begin
                    word  = 12'($urandom_range(0, 4095));
                    tries = tries + 1;
                end
                if (!instr_is_illegal(word)) begin
                    word = 12'hFCF; // Fallback unsupported code
                end
            end
        endcase
        return word;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("[FAIL] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "check failed");
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic wait_retires(input int count);
        int cycles;
        cycles = 0;
        while (retire_count < count) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles > 5 * count + 50) begin
                abort_on_timeout("expected number of retires not reached");
            end
        end
    endtask

    // Instruction fetch, driven just after the rising edge
    always @(posedge clk) begin
        #1;
        instr <= fetch_word(pc);
    end

    initial begin : compare
        int          gap;
        int          idle;
        logic        pending;
        logic        got_illegal;
        logic        exp_illegal;
        logic [11:0] word;
        gap         = 0;
        idle        = 0;
        pending     = 1'b0;
        got_illegal = 1'b0;
        forever begin
            @(negedge clk);
            if (!arst_n) begin
                idle = idle + 1;
                if (idle > RESET_LIMIT) begin
                    abort_on_timeout("reset was never released");
                end
            end else begin
                gap = gap + 1;
                if (pending) begin // State updated on the retire edge
                    word        = fetch_word(model.pc);
                    exp_illegal = instr_is_illegal(word);
                    model       = tama_step(model, model_mem, word);
                    check_value(64'(got_illegal), 64'(exp_illegal),
                                $sformatf("illegal strobe for %h", word));
                    check_value(64'(state), 64'(model), $sformatf("state after %h", word));
                    check_value(64'(pc), 64'(model.pc), "fetch address");
                    pending      = 1'b0;
                    retire_count = retire_count + 1;
                end
                if (retire) begin
                    check_value(64'(gap), 64'd5, "cycles between retires");
                    got_illegal = illegal;
                    gap         = 0;
                    pending     = 1'b1;
                end else begin
                    check_value(64'(illegal), 64'd0, "illegal outside retire");
                    if (gap > RETIRE_LIMIT) begin
                        abort_on_timeout("no retire pulse");
                    end
                end
            end
        end
    end

    initial begin : main
        clk          = 1'b0;
        arst_n       = 1'b0;
        instr        = NOP5;
        retire_count = 0;
        error_count  = 0;
        void'($urandom(33190));
        model    = '0;
        model.pc = RESET_PC;
        model.sp = RESET_SP;
        foreach (model_mem[i]) begin
            model_mem[i] = 4'h0;
        end
        foreach (DIRECTED[i]) begin
            prog.push_back(DIRECTED[i]);
        end
        repeat (N_RANDOM) begin
            prog.push_back(random_word());
        end

        repeat (8) @(negedge clk);
        check_value(64'(state), 64'(model), "state in reset");
        check_value(64'(retire), 64'd0, "retire in reset");
        check_value(64'(illegal), 64'd0, "illegal in reset");
        @(posedge clk);
        #1;
        arst_n = 1'b1;

        wait_retires(MARK_LD);
        check_value(64'(state.b), 64'hA, "B after POP B");
        check_value(64'(state.sp), 64'(RESET_SP), "SP after push and pop");
        check_value(64'(state.pc), 64'h104, "pc after four instructions");

        wait_retires(MARK_MEM);
        check_value(64'(state.a), 64'h7, "A popped from M(X)");
        check_value(64'(state.b), 64'hC, "B popped from M(Y)");
        check_value(64'(state.x), 64'h070, "X low nibble from unrelated RAM");

        wait_retires(MARK_NIB);
        check_value(64'(state.x), 64'h145, "X after nibble pops and LD X");
        check_value(64'(state.y), 64'hDEF, "Y after nibble pops");

        wait_retires(MARK_FLAG);
        check_value(64'(state.f.i), 64'd1, "flag i");
        check_value(64'(state.f.d), 64'd0, "flag d");
        check_value(64'(state.f.z), 64'd1, "flag z");
        check_value(64'(state.f.c), 64'd0, "flag c");
        check_value(64'(state.a), 64'hA, "A popped from pushed F");

        wait_retires(prog.size());
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== source/tama_core.sv ====
module tama_core
    import tama_pkg::*;
#(
    parameter int RAM_ADDR_W = 8
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [11:0] instr,
    output logic [11:0] pc,
    output arch_state_t state,
    output logic        retire,
    output logic        illegal
);

    phase_e                phase;
    decoded_t              dec;
    logic [11:0]           ir;
    logic [RAM_ADDR_W-1:0] ram_addr;
    logic [3:0]            ram_wdata;
    logic [3:0]            ram_rdata;
    logic                  ram_we;

    assign pc = state.pc; // Fetch address

    tama_sequencer u_sequencer (
        .clk     (clk),
        .arst_n  (arst_n),
        .instr   (instr),
        .dec     (dec),
        .ir      (ir),
        .phase   (phase),
        .ram_we  (ram_we),
        .retire  (retire),
        .illegal (illegal)
    );

    tama_decoder u_decoder (
        .ir  (ir),
        .dec (dec)
    );

    tama_regfile #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_regfile (
        .clk       (clk),
        .arst_n    (arst_n),
        .phase     (phase),
        .dec       (dec),
        .ram_rdata (ram_rdata),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .state     (state)
    );

    tama_ram #(
        .RAM_ADDR_W (RAM_ADDR_W)
    ) u_ram (
        .clk    (clk),
        .arst_n (arst_n),
        .addr   (ram_addr),
        .wdata  (ram_wdata),
        .we     (ram_we),
        .rdata  (ram_rdata)
    );

endmodule

// ==== source/tama_ram.sv ====
module tama_ram #(
    parameter int RAM_ADDR_W = 8
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [RAM_ADDR_W-1:0] addr,
    input  logic [3:0]            wdata,
    input  logic                  we,
    output logic [3:0]            rdata
);

    localparam int DEPTH = 1 << RAM_ADDR_W;

    logic [3:0] mem [DEPTH];

    assign rdata = mem[addr]; // Asynchronous read

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= 4'h0;
            end
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        we |-> !$isunknown(addr));

endmodule

// ==== source/tama_regfile.sv ====
module tama_regfile
    import tama_pkg::*;
#(
    parameter int RAM_ADDR_W = 8
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  phase_e                phase,
    input  decoded_t              dec,
    input  logic [3:0]            ram_rdata,
    output logic [RAM_ADDR_W-1:0] ram_addr,
    output logic [3:0]            ram_wdata,
    output arch_state_t           state
);

    logic [11:0] addr_full;
    logic [3:0]  mdr;
    logic [3:0]  opd_val;
    logic [3:0]  load_val;
    logic        reg_load;

    // SP for stack side, X or Y for the memory operand
    always_comb begin
        addr_full = (dec.opd == sel_my) ? state.y : state.x;
        if (((dec.op == op_push) && (phase == ph_write)) ||
            ((dec.op == op_pop) && (phase != ph_write))) begin
            addr_full = {4'h0, state.sp};
        end
    end

    assign ram_addr = addr_full[RAM_ADDR_W-1:0];

    always_comb begin
        case (dec.opd)
            sel_a:          opd_val = state.a;
            sel_b:          opd_val = state.b;
            sel_mx, sel_my: opd_val = mdr;
            sel_xp:         opd_val = state.x[11:8];
            sel_xh:         opd_val = state.x[7:4];
            sel_xl:         opd_val = state.x[3:0];
            sel_yp:         opd_val = state.y[11:8];
            sel_yh:         opd_val = state.y[7:4];
            sel_yl:         opd_val = state.y[3:0];
            sel_f:          opd_val = state.f;
            default:        opd_val = 4'h0;
        endcase
    end

    assign load_val  = (dec.op == op_pop) ? mdr : dec.imm[3:0];
    assign ram_wdata = (dec.op == op_push) ? opd_val : load_val;
    assign reg_load  = (dec.op == op_pop) || (dec.op == op_ld_ri);

    always_ff @(posedge clk) begin
        if (phase == ph_read) begin
            mdr <= ram_rdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= '0;
            state.pc <= RESET_PC;
            state.sp <= RESET_SP;
        end else begin
            if ((phase == ph_read) && (dec.op == op_push)) begin
                state.sp <= state.sp - 8'd1; // Pre-decrement
            end
            if (phase == ph_retire) begin
                state.pc <= state.pc + 12'd1;
                case (dec.op)
                    op_ld_x: state.x[7:0] <= dec.imm; // Page nibble kept
                    op_ld_y: state.y[7:0] <= dec.imm;
                    op_pop:  state.sp <= state.sp + 8'd1;
                    default: ;
                endcase
                if (reg_load) begin
                    case (dec.opd)
                        sel_a:   state.a <= load_val;
                        sel_b:   state.b <= load_val;
                        sel_xp:  state.x[11:8] <= load_val;
                        sel_xh:  state.x[7:4] <= load_val;
                        sel_xl:  state.x[3:0] <= load_val;
                        sel_yp:  state.y[11:8] <= load_val;
                        sel_yh:  state.y[7:4] <= load_val;
                        sel_yl:  state.y[3:0] <= load_val;
                        sel_f:   state.f <= flags_t'(load_val);
                        default: ; // MX/MY already stored in WRITE
                    endcase
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        $changed(state.sp) |->
            $past((phase == ph_read) && (dec.op == op_push)) ||
            $past((phase == ph_retire) && (dec.op == op_pop)));

endmodule

// ==== source/tama_sequencer.sv ====
module tama_sequencer
    import tama_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic [11:0] instr,
    input  decoded_t    dec,
    output logic [11:0] ir,
    output phase_e      phase,
    output logic        ram_we,
    output logic        retire,
    output logic        illegal
);

    phase_e phase_nxt;
    logic   mem_target;
    logic   stores;

    assign mem_target = (dec.opd == sel_mx) || (dec.opd == sel_my);

    // Operations that write RAM in WRITE
    assign stores = (dec.op == op_push) ||
                    (((dec.op == op_ld_ri) || (dec.op == op_pop)) && mem_target);

    always_comb begin
        case (phase)
            ph_fetch:  phase_nxt = ph_decode;
            ph_decode: phase_nxt = ph_read;
            ph_read:   phase_nxt = ph_write;
            ph_write:  phase_nxt = ph_retire;
            default:   phase_nxt = ph_fetch;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase   <= ph_fetch;
            ir      <= NOP5;
            ram_we  <= 1'b0;
            retire  <= 1'b0;
            illegal <= 1'b0;
        end else begin
            phase <= phase_nxt;
            if (phase == ph_fetch) begin
                ir <= instr; // Sampled at end of FETCH
            end
            // Strobes registered one phase ahead
            ram_we  <= (phase == ph_read) && stores;
            retire  <= (phase == ph_write);
            illegal <= (phase == ph_write) && (dec.op == op_illegal);
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        ram_we |-> (phase == ph_write));

    assert property (@(posedge clk) disable iff (!arst_n)
        retire |-> (phase == ph_retire));

    // Strict five-phase rotation
    assert property (@(posedge clk) disable iff (!arst_n)
        $past(arst_n) |-> (phase == (($past(phase) == ph_retire) ? ph_fetch :
                                     phase_e'($past(phase) + 3'd1))));

endmodule

// ==== source/tama_decoder.sv ====
module tama_decoder
    import tama_pkg::*;
(
    input  logic [11:0] ir,
    output decoded_t    dec
);

    logic is_ld_ri;
    logic is_ld_x;
    logic is_ld_y;
    logic is_push;
    logic is_pop;
    logic is_nop;
    logic stack_opd_ok;

    // Opcode ranges
    assign is_ld_ri     = (ir[11:6] == 6'b1110_00); // 0xE00..0xE3F
    assign is_ld_x      = (ir[11:8] == 4'hB);
    assign is_ld_y      = (ir[11:8] == 4'h8);
    assign stack_opd_ok = (ir[3:0] <= 4'hA);        // A..F only
    assign is_push      = (ir[11:4] == 8'hFC) && stack_opd_ok;
    assign is_pop       = (ir[11:4] == 8'hFD) && stack_opd_ok;
    assign is_nop       = (ir == NOP5);

    always_comb begin
        dec.op  = op_illegal;
        dec.opd = sel_a;
        dec.imm = ir[7:0];

        if (is_ld_ri) begin
            dec.op  = op_ld_ri;
            dec.opd = operand_e'({2'b00, ir[5:4]}); // r maps onto A, B, MX, MY
            dec.imm = {4'h0, ir[3:0]};
        end else if (is_ld_x) begin
            dec.op = op_ld_x;
        end else if (is_ld_y) begin
            dec.op = op_ld_y;
        end else if (is_push) begin
            dec.op  = op_push;
            dec.opd = operand_e'(ir[3:0]);
        end else if (is_pop) begin
            dec.op  = op_pop;
            dec.opd = operand_e'(ir[3:0]);
        end else if (is_nop) begin
            dec.op = op_nop;
        end
    end

endmodule

// ==== source/tama_pkg.sv ====
package tama_pkg;

    // Operation kinds after decode
    typedef enum logic [2:0] {
        op_ld_ri   = 3'd0,
        op_ld_x    = 3'd1,
        op_ld_y    = 3'd2,
        op_push    = 3'd3,
        op_pop     = 3'd4,
        op_nop     = 3'd5,
        op_illegal = 3'd6
    } opcode_e;

    // Register selection, same code as the low nibble of PUSH/POP
    typedef enum logic [3:0] {
        sel_a  = 4'h0,
        sel_b  = 4'h1,
        sel_mx = 4'h2,
        sel_my = 4'h3,
        sel_xp = 4'h4,
        sel_xh = 4'h5,
        sel_xl = 4'h6,
        sel_yp = 4'h7,
        sel_yh = 4'h8,
        sel_yl = 4'h9,
        sel_f  = 4'hA
    } operand_e;

    typedef enum logic [2:0] {
        ph_fetch  = 3'd0,
        ph_decode = 3'd1,
        ph_read   = 3'd2,
        ph_write  = 3'd3,
        ph_retire = 3'd4
    } phase_e;

    typedef struct packed {
        logic i; // Interrupt enable
        logic d; // Decimal mode
        logic z;
        logic c;
    } flags_t;

    typedef struct packed {
        opcode_e    op;
        operand_e   opd;
        logic [7:0] imm;
    } decoded_t;

    typedef struct packed {
        logic [11:0] pc;
        logic [3:0]  a;
        logic [3:0]  b;
        logic [11:0] x;
        logic [11:0] y;
        logic [7:0]  sp;
        flags_t      f;
    } arch_state_t;

    localparam logic [11:0] RESET_PC = 12'h100;
    localparam logic [7:0]  RESET_SP = 8'h00;
    localparam logic [11:0] NOP5     = 12'hFFB;

endpackage
